// File: common/cpuPkg.sv
// Core Shared Definitions
package cpuPkg;

    //////////////////////////////
    // Widths and queue sizing
    //////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    localparam int QueueDepth    = 4;
    localparam int QueuePtrWidth = 2;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        SLTIU = 6'b001011,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        LL    = 6'b110000,
        SC    = 6'b111000,
        HALT  = 6'b111111
    } opcode_t;

    typedef enum logic [5:0] {
        SLLV = 6'b000100,
        SRLV = 6'b000110,
        JR   = 6'b001000,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_t;

    //////////////////////////////
    // Datapath controls
    //////////////////////////////

    typedef enum logic [3:0] {
        ALU_SLL,
        ALU_SRL,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU
    } aluOp_t;

    typedef enum logic [2:0] {
        NEXT,
        JUMP,
        JUMPR,
        BREQ,
        BRNE,
        KEEP
    } pcSrc_t;

endpackage

// File: hw/instrQueue.sv
// Instruction Queue
`timescale 1ns/1ps

module instrQueue import cpuPkg::*; (
    input  logic  CLK,
    input  logic  rst,
    input  logic  instrValid,
    output logic  instrReady,
    input  word_t instr,
    output logic  qValid,
    input  logic  qReady,
    output word_t qInstr
);

    word_t                    mem [QueueDepth];
    logic [QueuePtrWidth-1:0] wrPtr;
    logic [QueuePtrWidth-1:0] rdPtr;
    logic [QueuePtrWidth:0]   count;
    logic                     push;
    logic                     pop;

    assign instrReady = (count != QueueDepth); // Not full.
    assign qValid     = (count != 0);          // Not empty.
    assign qInstr     = mem[rdPtr];

    assign push = instrValid && instrReady;
    assign pop  = qValid && qReady;

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1; // Wraps at depth.
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy always matches the pointer distance.
    assert property (@(posedge CLK) disable iff (rst)
        count[QueuePtrWidth-1:0] == wrPtr - rdPtr);

    assert property (@(posedge CLK) disable iff (rst)
        count <= QueueDepth);

endmodule

// File: core/controlUnit.sv
// Instruction Decoder
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  opcode_t opcode,
    input  funct_t  funct,
    output logic    regDst,
    output logic    regWr,
    output logic    memWr,
    output logic    memRd,
    output logic    memToReg,
    output logic    aluSrc,
    output logic    extOp,
    output logic    shiftUp,
    output logic    wrLinkReg,
    output logic    atomic,
    output logic    halt,
    output pcSrc_t  pcSrc,
    output aluOp_t  aluOp
);

    typedef enum logic [2:0] {
        GRP_SUB,
        GRP_OR,
        GRP_AND,
        GRP_XOR,
        GRP_RTYPE,
        GRP_ADD,
        GRP_SLT,
        GRP_SLTU
    } aluGroup_t;

    aluGroup_t aluGroup;

    //////////////////////////////
    // Opcode decode
    //////////////////////////////

    always_comb begin
        aluGroup  = GRP_SUB;
        regDst    = 1'b0;
        regWr     = 1'b0;
        memWr     = 1'b0;
        memRd     = 1'b0;
        memToReg  = 1'b0;
        aluSrc    = 1'b0;
        extOp     = 1'b0;
        shiftUp   = 1'b0;
        wrLinkReg = 1'b0;
        atomic    = 1'b0;
        halt      = 1'b0;
        pcSrc     = NEXT;
        case (opcode)
            RTYPE: begin
                aluGroup = GRP_RTYPE;
                if (funct == JR) begin
                    pcSrc = JUMPR;
                end else if (funct != 6'd0) begin
                    regDst = 1'b1; // Funct zero is a no-op.
                    regWr  = 1'b1;
                end
            end
            J: pcSrc = JUMP;
            JAL: begin
                wrLinkReg = 1'b1;
                regWr     = 1'b1;
                pcSrc     = JUMP;
            end
            BEQ, BNE: begin
                pcSrc = (opcode == BEQ) ? BREQ : BRNE;
                extOp = 1'b1;
            end
            ADDI, ADDIU, SLTI, SLTIU: begin
                aluGroup = (opcode == SLTI)  ? GRP_SLT  :
                           (opcode == SLTIU) ? GRP_SLTU : GRP_ADD;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1; // Signed immediate.
            end
            ANDI, ORI, XORI, LUI: begin
                aluGroup = (opcode == ANDI) ? GRP_AND :
                           (opcode == XORI) ? GRP_XOR : GRP_OR;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                shiftUp  = (opcode == LUI);
            end
            LW, LL: begin
                aluGroup = GRP_ADD;
                memRd    = 1'b1;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                extOp    = 1'b1;
                atomic   = (opcode == LL);
            end
            SW, SC: begin
                aluGroup = GRP_ADD;
                memWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1;
                atomic   = (opcode == SC);
            end
            HALT: begin
                halt  = 1'b1;
                pcSrc = KEEP;
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // ALU operation select
    //////////////////////////////

    always_comb begin
        aluOp = ALU_SUB;
        case (aluGroup)
            GRP_SUB:  aluOp = ALU_SUB;
            GRP_OR:   aluOp = ALU_OR;
            GRP_AND:  aluOp = ALU_AND;
            GRP_XOR:  aluOp = ALU_XOR;
            GRP_ADD:  aluOp = ALU_ADD;
            GRP_SLT:  aluOp = ALU_SLT;
            GRP_SLTU: aluOp = ALU_SLTU;
            GRP_RTYPE: begin
                case (funct)
                    SLLV:      aluOp = ALU_SLL;
                    SRLV:      aluOp = ALU_SRL;
                    ADD, ADDU: aluOp = ALU_ADD; // No overflow trap.
                    SUB, SUBU: aluOp = ALU_SUB;
                    AND:       aluOp = ALU_AND;
                    OR:        aluOp = ALU_OR;
                    XOR:       aluOp = ALU_XOR;
                    NOR:       aluOp = ALU_NOR;
                    SLT:       aluOp = ALU_SLT;
                    SLTU:      aluOp = ALU_SLTU;
                    default:   aluOp = ALU_SUB;
                endcase
            end
            default: aluOp = ALU_SUB;
        endcase
    end

endmodule

// File: core/aluUnit.sv
// Arithmetic Logic Unit
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
    input  word_t  portA,
    input  word_t  portB,
    input  aluOp_t aluOp,
    output word_t  result
);

    logic [4:0] shamt;

    assign shamt = portA[4:0]; // Variable shifts take rs.

    always_comb begin
        case (aluOp)
            ALU_SLL:  result = portB << shamt;
            ALU_SRL:  result = portB >> shamt;
            ALU_ADD:  result = portA + portB;
            ALU_SUB:  result = portA - portB;
            ALU_AND:  result = portA & portB;
            ALU_OR:   result = portA | portB;
            ALU_XOR:  result = portA ^ portB;
            ALU_NOR:  result = ~(portA | portB);
            ALU_SLT: begin
                result = ($signed(portA) < $signed(portB)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (portA < portB) ? 32'd1 : 32'd0;
            end
            default:  result = '0;
        endcase
    end

endmodule

// File: core/regFile.sv
// Register File
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    output word_t    rdDataA,
    output word_t    rdDataB
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData; // Register zero never changes.
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: core/executeStage.sv
// Execute Stage
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     qValid,
    output logic     qReady,
    input  word_t    qInstr,
    output logic     wbValid,
    input  logic     wbReady,
    output regAddr_t wbReg,
    output word_t    wbData,
    output logic     halted
);

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    regAddr_t rdAddrA;
    regAddr_t destReg;
    word_t    immVal;
    word_t    rdDataA;
    word_t    rdDataB;
    word_t    portB;
    word_t    aluResult;
    logic     regDst, regWr, memWr, memRd, memToReg, aluSrc;
    logic     extOp, shiftUp, wrLinkReg, atomic, halt;
    pcSrc_t   pcSrc;
    aluOp_t   aluOp;
    logic     noEffect;
    logic     doWrite;
    logic     accept;

    //////////////////////////////
    // Decode and operands
    //////////////////////////////

    assign opcode = opcode_t'(qInstr[31:26]);
    assign funct  = funct_t'(qInstr[5:0]);
    assign rs     = qInstr[25:21];
    assign rt     = qInstr[20:16];
    assign rd     = qInstr[15:11];

    always_comb begin
        if (shiftUp) begin
            immVal = {qInstr[15:0], 16'h0000};
        end else if (extOp) begin
            immVal = {{16{qInstr[15]}}, qInstr[15:0]};
        end else begin
            immVal = {16'h0000, qInstr[15:0]};
        end
    end

    assign rdAddrA = shiftUp ? '0 : rs; // LUI ORs with register zero.
    assign portB   = aluSrc ? immVal : rdDataB;
    assign destReg = regDst ? rd : rt;

    controlUnit u_control (
        .opcode, .funct, .regDst, .regWr, .memWr, .memRd, .memToReg, .aluSrc,
        .extOp, .shiftUp, .wrLinkReg, .atomic, .halt, .pcSrc, .aluOp
    );

    regFile u_regs (
        .CLK, .rst, .wrEn(accept && doWrite), .wrAddr(destReg), .wrData(aluResult),
        .rdAddrA, .rdAddrB(rt), .rdDataA, .rdDataB
    );

    aluUnit u_alu (.portA(rdDataA), .portB, .aluOp, .result(aluResult));

    //////////////////////////////
    // Retire and writeback
    //////////////////////////////

    // No PC and no data memory, so these retire silently.
    assign noEffect = memRd || memWr || memToReg || atomic || wrLinkReg || (pcSrc != NEXT);
    assign doWrite  = regWr && !noEffect && (destReg != '0);

    assign qReady = !halted && (!wbValid || wbReady);
    assign accept = qValid && qReady;

    always_ff @(posedge CLK) begin
        if (rst) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
        end else begin
            if (accept && doWrite) begin
                wbValid <= 1'b1;
            end else if (wbReady) begin
                wbValid <= 1'b0; // Drained.
            end
            if (accept && halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept && doWrite) begin
            wbReg  <= destReg;
            wbData <= aluResult;
        end
    end

    assert property (@(posedge CLK) disable iff (rst)
        (wbValid && !wbReady) |=> wbValid && $stable(wbReg) && $stable(wbData));

endmodule

// File: hw/miniCore.sv
// Mini Execute Core
`timescale 1ns/1ps

module miniCore import cpuPkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     instrValid,
    output logic     instrReady,
    input  word_t    instr,
    output logic     wbValid,
    input  logic     wbReady,
    output regAddr_t wbReg,
    output word_t    wbData,
    output logic     halted
);

    logic  qValid;
    logic  qReady;
    word_t qInstr;

    instrQueue u_queue (
        .CLK        (CLK),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .qValid     (qValid),
        .qReady     (qReady),
        .qInstr     (qInstr)
    );

    executeStage u_exec (
        .CLK     (CLK),
        .rst     (rst),
        .qValid  (qValid),
        .qReady  (qReady),
        .qInstr  (qInstr),
        .wbValid (wbValid),
        .wbReady (wbReady),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .halted  (halted)
    );

endmodule

// File: verification/miniCoreTb.sv
// Mini Core Testbench
`timescale 1ns/1ps

module miniCoreTb import cpuPkg::*; ();

    localparam int   ClkHalf       = 50;   // 100 ns period.
    localparam int   DriveDelay    = 10;
    localparam int   ResetCycles   = 4;
    localparam int   TimeoutCycles = 2000; // Tests need under 600.
    localparam logic [31:0] LfsrSeed = 32'hf8c1_c55a;
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;

    logic     CLK;
    logic     rst;
    logic     instrValid;
    logic     instrReady;
    word_t    instr;
    logic     wbValid;
    logic     wbReady;
    regAddr_t wbReg;
    word_t    wbData;
    logic     halted;

    word_t       modelRegs [32];
    logic        haltSeen;
    regAddr_t    expRegQ [$];
    word_t       expDataQ [$];
    regAddr_t    expReg;
    word_t       expData;
    logic [31:0] lfsrState;
    int          cycleCount = 0;

    miniCore u_dut (
        .CLK        (CLK),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReady    (wbReady),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .halted     (halted)
    );

    initial begin
        CLK = 1'b0;
        forever #ClkHalf CLK = ~CLK;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Run stopped on error.");
    endtask

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            abortRun($sformatf("Timeout: run passed %0d cycles", TimeoutCycles));
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic lfsrStep();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ LfsrTaps;
        end
        return outBit;
    endfunction

    function automatic regAddr_t randomReg();
        regAddr_t r = '0;
        for (int i = 0; i < 5; i++) begin
            r = {r[3:0], lfsrStep()};
        end
        return (r == '0) ? 5'd1 : r; // Never register zero.
    endfunction

    function automatic logic [15:0] randomImm();
        logic [15:0] v = '0;
        for (int i = 0; i < 16; i++) begin
            v = {v[14:0], lfsrStep()};
        end
        return v;
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd, logic [5:0] fn);
        return {6'b000000, rs, rt, rd, 5'b00000, fn};
    endfunction

    // Reference model stepping one instruction in program order.
    task automatic modelExecute(input word_t w);
        word_t    a;
        word_t    b;
        word_t    sImm;
        word_t    zImm;
        word_t    val;
        regAddr_t dst;
        logic     wr;
        logic     wasHalted;
        a         = modelRegs[w[25:21]];
        b         = modelRegs[w[20:16]];
        sImm      = {{16{w[15]}}, w[15:0]};
        zImm      = {16'h0000, w[15:0]};
        dst       = w[20:16];
        wr        = 1'b1;
        val       = '0;
        wasHalted = haltSeen;
        case (opcode_t'(w[31:26]))
            RTYPE: begin
                dst = w[15:11];
                case (funct_t'(w[5:0]))
                    SLLV:      val = b << a[4:0];
                    SRLV:      val = b >> a[4:0];
                    ADD, ADDU: val = a + b;
                    SUB, SUBU: val = a - b;
                    AND:       val = a & b;
                    OR:        val = a | b;
                    XOR:       val = a ^ b;
                    NOR:       val = ~(a | b);
                    SLT:       val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    SLTU:      val = (a < b) ? 32'd1 : 32'd0;
                    default:   wr = 1'b0; // Funct zero and JR.
                endcase
            end
            ADDI, ADDIU: val = a + sImm;
            SLTI:        val = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            SLTIU:       val = (a < sImm) ? 32'd1 : 32'd0;
            ANDI:        val = a & zImm;
            ORI:         val = a | zImm;
            XORI:        val = a ^ zImm;
            LUI:         val = {w[15:0], 16'h0000};
            HALT: begin
                wr       = 1'b0;
                haltSeen = 1'b1;
            end
            default:     wr = 1'b0;
        endcase
        if (wr && (dst != '0) && !wasHalted) begin
            modelRegs[dst] = val;
            expRegQ.push_back(dst);
            expDataQ.push_back(val);
        end
    endtask

    task automatic sendWord(input word_t w);
        instrValid = 1'b1;
        instr      = w;
        while (!instrReady) begin
            @(posedge CLK);
            #DriveDelay;
        end
        @(posedge CLK); // Transfer edge.
        #DriveDelay;
        instrValid = 1'b0;
    endtask

    task automatic issue(input word_t w);
        modelExecute(w);
        sendWord(w);
    endtask

    task automatic waitDrained();
        while (expRegQ.size() != 0) begin
            @(posedge CLK);
        end
        #DriveDelay;
    endtask

    // Writeback signals are stable at the falling edge.
    always @(negedge CLK) begin
        if (!rst && wbValid && wbReady) begin
            assert (expRegQ.size() != 0) else begin
                abortRun($sformatf("Unexpected writeback to r%0d at %0t", wbReg, $time));
            end
            if (expRegQ.size() != 0) begin
                expReg  = expRegQ.pop_front();
                expData = expDataQ.pop_front();
                assert ((wbReg == expReg) && (wbData == expData)) else begin
                    abortRun($sformatf("FAILED at %0t: got r%0d = %h, expected r%0d = %h",
                        $time, wbReg, wbData, expReg, expData));
                end
            end
        end
    end

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic checkResetState();
        assert (instrReady && !wbValid && !halted) else begin
            abortRun("Outputs after reset are not idle");
        end
    endtask

    task automatic testIType();
        opcode_t  iOps [6];
        regAddr_t r;
        iOps = '{ADDI, SLTI, SLTIU, ANDI, XORI, LUI};
        for (int i = 0; i < 8; i++) begin
            r = randomReg();
            issue(iType(ADDIU, 5'd0, r, randomImm()));
            issue(iType(ORI, r, r, randomImm()));
        end
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 4; i++) begin
                issue(iType(iOps[k], randomReg(), randomReg(), randomImm()));
            end
        end
        waitDrained();
    endtask

    task automatic testRType();
        funct_t   rOps [12];
        regAddr_t a;
        regAddr_t b;
        regAddr_t c;
        rOps = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLLV, SRLV};
        for (int k = 0; k < 12; k++) begin
            for (int i = 0; i < 3; i++) begin
                issue(rType(randomReg(), randomReg(), randomReg(), rOps[k]));
            end
        end
        a = randomReg();
        b = randomReg();
        c = randomReg();
        issue(rType(a, b, c, ADDU)); // Chain reads fresh results.
        issue(rType(c, a, b, SUBU));
        issue(rType(b, c, a, SLLV));
        issue(rType(a, b, c, SLT));
        waitDrained();
    endtask

    task automatic testSilent();
        opcode_t quietOps [8];
        quietOps = '{J, JAL, BEQ, BNE, LW, SW, LL, SC};
        issue(iType(ADDIU, 5'd0, randomReg(), randomImm()));
        issue(rType(randomReg(), randomReg(), 5'd0, ADDU));
        issue(iType(ORI, randomReg(), 5'd0, randomImm()));
        issue(rType(randomReg(), randomReg(), randomReg(), 6'd0));
        issue(rType(randomReg(), 5'd0, 5'd0, JR));
        for (int k = 0; k < 8; k++) begin
            issue(iType(quietOps[k], randomReg(), randomReg(), randomImm()));
        end
        issue(iType(ADDIU, randomReg(), randomReg(), randomImm()));
        waitDrained();
    endtask

    task automatic testBackPressure();
        int accepted;
        accepted = 0;
        wbReady  = 1'b0;
        while (instrReady && (accepted < QueueDepth + 3)) begin
            issue(iType(ADDIU, randomReg(), randomReg(), randomImm()));
            accepted++;
        end
        assert (!instrReady && (accepted <= QueueDepth + 2)) else begin
            abortRun($sformatf("instrReady still high after %0d words", accepted));
        end
        repeat (5) @(posedge CLK);
        #DriveDelay;
        assert (!instrReady) else begin
            abortRun("Queue drained while writeback was stalled");
        end
        wbReady = 1'b1;
        waitDrained();
    endtask

    task automatic testHalt();
        for (int i = 0; i < 3; i++) begin
            issue(iType(XORI, randomReg(), randomReg(), randomImm()));
        end
        issue(iType(HALT, 5'd0, 5'd0, 16'h0000));
        for (int i = 0; i < QueueDepth; i++) begin
            issue(iType(ADDIU, randomReg(), randomReg(), randomImm()));
        end
        while (!halted) begin
            @(posedge CLK);
        end
        waitDrained();
        repeat (20) @(posedge CLK);
        #DriveDelay;
        assert (halted && !instrReady) else begin
            abortRun("Core left the halted state or took words after HALT");
        end
    endtask

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        wbReady    = 1'b1;
        lfsrState  = LfsrSeed;
        haltSeen   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (ResetCycles) @(posedge CLK);
        #DriveDelay;
        rst = 1'b0;

        checkResetState();
        testIType();
        testRType();
        testSilent();
        testBackPressure();
        testHalt();

        $display("Test OK");
        $finish;
    end

endmodule

// File: files.f
common/cpuPkg.sv
hw/instrQueue.sv
core/controlUnit.sv
core/aluUnit.sv
core/regFile.sv
core/executeStage.sv
hw/miniCore.sv
verification/miniCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module miniCoreTb -f files.f -o miniCoreSim

./obj_dir/miniCoreSim | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed." >&2
    exit 1
fi
